// ==== mm_feed_defs.svh ====
`ifndef MM_FEED_DEFS_SVH
`define MM_FEED_DEFS_SVH

// array edge, one byte per lane
`define MM_LANES 16
`define MM_BYTE_W 8

// scratchpad geometry, one line holds one byte per lane
`define MM_LINE_W 128
`define MM_SPAD_DEPTH 256

// byte address = {line address, byte offset}
`define MM_LINE_ADDR_W 8
`define MM_BYTE_ADDR_W 12

`endif

// ==== mm_mem_pkg.sv ====
`default_nettype none

`include "mm_feed_defs.svh"

package mm_mem_pkg;

    // one scratchpad line
    typedef logic [`MM_LINE_W-1:0] line_t;

    // line index into the scratchpad
    typedef logic [`MM_LINE_ADDR_W-1:0] line_addr_t;

    // upper bits select the line, lower bits the byte of element 0
    typedef logic [`MM_BYTE_ADDR_W-1:0] byte_addr_t;

endpackage

`default_nettype wire

// ==== mm_array_pkg.sv ====
`default_nettype none

`include "mm_feed_defs.svh"

package mm_array_pkg;

    // count minus one, for rows and columns of a tile
    typedef logic [$clog2(`MM_LANES)-1:0] len_t;

    // one valid bit per array lane
    typedef logic [`MM_LANES-1:0] lane_mask_t;

    // drain cycle t, up to row_len + col_len
    typedef logic [5:0] drain_cnt_t;

    // activations go on lane r, weights on lane 15-r
    typedef enum logic {
        OPERAND_ACT,
        OPERAND_WGT
    } operand_kind_t;

    typedef enum logic [1:0] {
        SKEW_IDLE,
        SKEW_FILL,
        SKEW_DRAIN,
        SKEW_DONE
    } skew_state_t;

endpackage

`default_nettype wire

// ==== spad_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spad_rd_if import mm_mem_pkg::*;;

    // held by the requester until grant
    logic       req;
    line_addr_t addr;

    // rdata_vld follows grant by one cycle
    logic       grant;
    logic       rdata_vld;
    line_t      rdata;

    modport requester (
        output req,
        output addr,
        input  grant,
        input  rdata_vld,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output rdata_vld,
        output rdata
    );

endinterface

`default_nettype wire

// ==== spad_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_feed_defs.svh"

module spad_ram import mm_mem_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,

    // host write port
    input  wire logic       wr_en,
    input  wire line_addr_t wr_addr,
    input  wire line_t      wr_data,

    // read port, data one cycle after rd_en
    input  wire logic       rd_en,
    input  wire line_addr_t rd_addr,
    output line_t           rd_data
);

    line_t mem [`MM_SPAD_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // single port, a write takes the cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en && !wr_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== spad_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spad_arbiter import mm_mem_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,

    spad_rd_if.arbiter      act,
    spad_rd_if.arbiter      wgt,

    // RAM port
    input  wire logic       wr_en,
    output logic            rd_en,
    output line_addr_t      rd_addr,
    input  wire line_t      rd_data
);

    // 1 when the weight buffer wins the next contention
    logic rr_wgt;
    logic pick_wgt;

    // which requester the read in flight belongs to
    logic rd_vld_q;
    logic rd_wgt_q;

    always_comb begin
        pick_wgt = wgt.req && (!act.req || rr_wgt);
        // host write owns the RAM this cycle
        rd_en    = !wr_en && (act.req || wgt.req);
        rd_addr  = pick_wgt ? wgt.addr : act.addr;
    end

    assign act.grant = rd_en && !pick_wgt;
    assign wgt.grant = rd_en && pick_wgt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_wgt   <= 1'b0;
            rd_vld_q <= 1'b0;
            rd_wgt_q <= 1'b0;
        end else begin
            rd_vld_q <= rd_en;
            if (rd_en) begin
                rd_wgt_q <= pick_wgt;
            end
            // alternate only when both were asking
            if (rd_en && act.req && wgt.req) begin
                rr_wgt <= !pick_wgt;
            end
        end
    end

    // return path, line goes to whoever was granted
    assign act.rdata_vld = rd_vld_q && !rd_wgt_q;
    assign wgt.rdata_vld = rd_vld_q && rd_wgt_q;
    assign act.rdata     = rd_data;
    assign wgt.rdata     = rd_data;

endmodule

`default_nettype wire

// ==== mm_skew_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_feed_defs.svh"

module mm_skew_buffer import mm_mem_pkg::*, mm_array_pkg::*; #(
    parameter operand_kind_t KIND = OPERAND_ACT
) (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // job control, rising edge of start begins a job
    input  wire logic                          start,
    input  wire len_t                          row_len,
    input  wire len_t                          col_len,
    input  wire byte_addr_t                    start_addr,

    spad_rd_if.requester                       spad,

    // array edge
    output lane_mask_t                         vld,
    output logic [`MM_LANES*`MM_BYTE_W-1:0]    data,
    output logic                               drain_end
);

    // width of the byte offset within a line
    localparam int OFS_W = `MM_BYTE_ADDR_W - `MM_LINE_ADDR_W;

    skew_state_t       state;
    logic              start_q;
    logic              job_go;

    // latched job
    len_t              row_len_q;
    len_t              col_len_q;
    line_addr_t        base_q;
    logic [OFS_W-1:0]  offset_q;

    // tile row indices for requests and arrivals
    len_t              req_cnt;
    logic              req_done;
    len_t              fill_cnt;

    drain_cnt_t        t;
    drain_cnt_t        t_last;

    line_t             rf [`MM_LANES];

    assign job_go = start && !start_q && (state == SKEW_IDLE);
    assign t_last = drain_cnt_t'(row_len_q) + drain_cnt_t'(col_len_q);

    always_ff @(posedge clk) begin
        if (job_go) begin
            row_len_q <= row_len;
            col_len_q <= col_len;
            base_q    <= start_addr[`MM_BYTE_ADDR_W-1:OFS_W];
            offset_q  <= start_addr[OFS_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SKEW_IDLE;
            start_q  <= 1'b0;
            req_cnt  <= '0;
            req_done <= 1'b0;
            fill_cnt <= '0;
            t        <= '0;
        end else begin
            start_q <= start;
            case (state)
                SKEW_IDLE: begin
                    if (job_go) begin
                        req_cnt  <= '0;
                        req_done <= 1'b0;
                        fill_cnt <= '0;
                        state    <= SKEW_FILL;
                    end
                end
                SKEW_FILL: begin
                    if (spad.grant) begin
                        req_cnt <= req_cnt + 1'b1;
                        if (req_cnt == row_len_q) begin
                            req_done <= 1'b1;
                        end
                    end
                    // last line in, drain starts next cycle
                    if (spad.rdata_vld) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == row_len_q) begin
                            t     <= '0;
                            state <= SKEW_DRAIN;
                        end
                    end
                end
                SKEW_DRAIN: begin
                    t <= t + 1'b1;
                    if (t == t_last) begin
                        state <= SKEW_DONE;
                    end
                end
                SKEW_DONE: begin
                    // wait for start to drop before rearming
                    if (!start) begin
                        state <= SKEW_IDLE;
                    end
                end
                default: begin
                    state <= SKEW_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SKEW_FILL && spad.rdata_vld) begin
            rf[fill_cnt] <= spad.rdata;
        end
    end

    assign spad.req  = (state == SKEW_FILL) && !req_done;
    assign spad.addr = base_q + line_addr_t'(req_cnt);

    assign drain_end = (state == SKEW_DRAIN) && (t == t_last);

    // row r feeds element k = t - r in drain cycle t
    for (genvar r = 0; r < `MM_LANES; r++) begin : g_row
        localparam int LANE = (KIND == OPERAND_ACT) ? r : `MM_LANES - 1 - r;

        drain_cnt_t       k;
        logic [OFS_W-1:0] sh;
        logic             row_vld;

        always_comb begin
            k       = t - drain_cnt_t'(r);
            // wraps within the line
            sh      = offset_q + k[OFS_W-1:0];
            row_vld = (state == SKEW_DRAIN)
                   && (len_t'(r) <= row_len_q)
                   && (t >= drain_cnt_t'(r))
                   && (k <= drain_cnt_t'(col_len_q));
        end

        // byte sh is byte 0 of the line rotated right by sh bytes
        assign vld[LANE] = row_vld;
        assign data[LANE*`MM_BYTE_W +: `MM_BYTE_W] =
            row_vld ? rf[r][sh*`MM_BYTE_W +: `MM_BYTE_W] : '0;
    end

endmodule

`default_nettype wire

// ==== mm_feed_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_feed_defs.svh"

module mm_feed_top import mm_mem_pkg::*, mm_array_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // host load of the scratchpad
    input  wire logic                          wr_en,
    input  wire line_addr_t                    wr_addr,
    input  wire line_t                         wr_data,

    // activation job
    input  wire logic                          act_start,
    input  wire len_t                          act_row_len,
    input  wire len_t                          act_col_len,
    input  wire byte_addr_t                    act_start_addr,

    // weight job
    input  wire logic                          wgt_start,
    input  wire len_t                          wgt_row_len,
    input  wire len_t                          wgt_col_len,
    input  wire byte_addr_t                    wgt_start_addr,

    // array edges
    output lane_mask_t                         act_vld,
    output logic [`MM_LANES*`MM_BYTE_W-1:0]    act_data,
    output logic                               act_end,
    output lane_mask_t                         wgt_vld,
    output logic [`MM_LANES*`MM_BYTE_W-1:0]    wgt_data,
    output logic                               wgt_end
);

    logic       rd_en;
    line_addr_t rd_addr;
    line_t      rd_data;

    spad_rd_if act_rd ();
    spad_rd_if wgt_rd ();

    spad_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    spad_arbiter u_arb (
        .clk     (clk),
        .rst     (rst),
        .act     (act_rd),
        .wgt     (wgt_rd),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    mm_skew_buffer #(.KIND(OPERAND_ACT)) act_buf (
        .clk        (clk),
        .rst        (rst),
        .start      (act_start),
        .row_len    (act_row_len),
        .col_len    (act_col_len),
        .start_addr (act_start_addr),
        .spad       (act_rd),
        .vld        (act_vld),
        .data       (act_data),
        .drain_end  (act_end)
    );

    // lanes reversed on the weight edge
    mm_skew_buffer #(.KIND(OPERAND_WGT)) wgt_buf (
        .clk        (clk),
        .rst        (rst),
        .start      (wgt_start),
        .row_len    (wgt_row_len),
        .col_len    (wgt_col_len),
        .start_addr (wgt_start_addr),
        .spad       (wgt_rd),
        .vld        (wgt_vld),
        .data       (wgt_data),
        .drain_end  (wgt_end)
    );

endmodule

`default_nettype wire

// ==== mm_feed_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_feed_defs.svh"

module mm_feed_tb;

    localparam int NJOBS   = 5;
    localparam int TIMEOUT = 200;
    localparam int NT      = 34;
    localparam int LW      = `MM_LINE_W;

    logic          clk;
    logic          rst;
    logic          wr_en;
    logic [7:0]    wr_addr;
    logic [LW-1:0] wr_data;
    logic          act_start;
    logic [3:0]    act_row_len;
    logic [3:0]    act_col_len;
    logic [11:0]   act_start_addr;
    logic          wgt_start;
    logic [3:0]    wgt_row_len;
    logic [3:0]    wgt_col_len;
    logic [11:0]   wgt_start_addr;
    logic [15:0]   act_vld;
    logic [15:0]   wgt_vld;
    logic [LW-1:0] act_data;
    logic [LW-1:0] wgt_data;
    logic          act_end;
    logic          wgt_end;

    // job table, second index 0 for activations and 1 for weights
    int            job_row  [NJOBS][2];
    int            job_col  [NJOBS][2];
    logic [11:0]   job_addr [NJOBS][2];
    bit            job_en   [NJOBS][2];
    bit            job_hw   [NJOBS];
    logic [15:0]   exp_vld  [NJOBS][2][NT];
    logic [LW-1:0] exp_data [NJOBS][2][NT];

    logic [LW-1:0] ram_copy [64];
    logic [31:0]   lfsr;
    int            errors;
    int            checks;

    mm_feed_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .act_start      (act_start),
        .act_row_len    (act_row_len),
        .act_col_len    (act_col_len),
        .act_start_addr (act_start_addr),
        .wgt_start      (wgt_start),
        .wgt_row_len    (wgt_row_len),
        .wgt_col_len    (wgt_col_len),
        .wgt_start_addr (wgt_start_addr),
        .act_vld        (act_vld),
        .act_data       (act_data),
        .act_end        (act_end),
        .wgt_vld        (wgt_vld),
        .wgt_data       (wgt_data),
        .wgt_end        (wgt_end)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_val(input string name, input logic [LW-1:0] exp,
                             input logic [LW-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic set_job(input int j, input int op, input int row, input int col,
                           input logic [11:0] addr);
        job_en[j][op]   = 1'b1;
        job_row[j][op]  = row;
        job_col[j][op]  = col;
        job_addr[j][op] = addr;
    endtask

    // element (r,k) leaves in drain cycle r+k on lane r, or 15-r for weights
    task automatic build_expected(input int j, input int op);
        int k;
        int lane;
        int row_line;
        int bsel;
        for (int t = 0; t < NT; t++) begin
            exp_vld[j][op][t]  = '0;
            exp_data[j][op][t] = '0;
            for (int r = 0; r < 16; r++) begin
                k = t - r;
                if (job_en[j][op] && r <= job_row[j][op] && k >= 0 && k <= job_col[j][op]) begin
                    lane     = (op == 0) ? r : 15 - r;
                    row_line = job_addr[j][op][11:4] + r;
                    bsel     = (job_addr[j][op][3:0] + k) % 16;
                    exp_vld[j][op][t][lane] = 1'b1;
                    exp_data[j][op][t][lane*8 +: 8] = ram_copy[row_line][bsel*8 +: 8];
                end
            end
        end
    endtask

    task automatic collect(input int j, input int op);
        string       pfx;
        logic [15:0] v;
        int          n;
        int          last;
        pfx  = (op == 0) ? "act" : "wgt";
        last = job_row[j][op] + job_col[j][op];
        v    = '0;
        n    = 0;
        if (job_en[j][op]) begin
            // drain starts at the first cycle with a valid lane
            while (v == '0 && n < TIMEOUT) begin
                @(negedge clk);
                v = (op == 0) ? act_vld : wgt_vld;
                n++;
            end
            if (v == '0) begin
                $display("timeout: job %0d, %s stream never became valid", j, pfx);
                errors++;
            end else begin
                // three extra cycles, start still high, vld must stay zero
                for (int t = 0; t <= last + 3; t++) begin
                    if (t > 0) begin
                        @(negedge clk);
                    end
                    check_val({pfx, "_vld"}, exp_vld[j][op][t], (op == 0) ? act_vld : wgt_vld);
                    check_val({pfx, "_data"}, exp_data[j][op][t],
                              (op == 0) ? act_data : wgt_data);
                    check_val({pfx, "_end"}, t == last, (op == 0) ? act_end : wgt_end);
                end
            end
        end
    endtask

    // host writes to lines the jobs never read
    task automatic host_traffic(input bit en);
        if (en) begin
            for (int i = 0; i < 6; i++) begin
                repeat (2) @(negedge clk);
                wr_en   = 1'b1;
                wr_addr = 8'(200 + i);
                wr_data = {16{8'(i + 1)}};
                @(negedge clk);
                wr_en   = 1'b0;
            end
        end
    endtask

    task automatic run_job(input int j);
        @(negedge clk);
        act_row_len    = 4'(job_row[j][0]);
        act_col_len    = 4'(job_col[j][0]);
        act_start_addr = job_addr[j][0];
        act_start      = job_en[j][0];
        wgt_row_len    = 4'(job_row[j][1]);
        wgt_col_len    = 4'(job_col[j][1]);
        wgt_start_addr = job_addr[j][1];
        wgt_start      = job_en[j][1];
        fork
            collect(j, 0);
            collect(j, 1);
            host_traffic(job_hw[j]);
        join
        @(negedge clk);
        act_start = 1'b0;
        wgt_start = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        act_start      = 1'b0;
        act_row_len    = '0;
        act_col_len    = '0;
        act_start_addr = '0;
        wgt_start      = 1'b0;
        wgt_row_len    = '0;
        wgt_col_len    = '0;
        wgt_start_addr = '0;
        errors         = 0;
        checks         = 0;
        lfsr           = 32'h42d4aa5d;
        for (int j = 0; j < NJOBS; j++) begin
            job_hw[j] = 1'b0;
            for (int op = 0; op < 2; op++) begin
                job_en[j][op]   = 1'b0;
                job_row[j][op]  = 0;
                job_col[j][op]  = 0;
                job_addr[j][op] = '0;
            end
        end
        set_job(0, 0, 3, 5, {8'd4, 4'd0});
        set_job(1, 1, 15, 15, {8'd20, 4'd9});
        set_job(2, 0, 7, 10, {8'd40, 4'd3});
        set_job(2, 1, 9, 4, {8'd10, 4'd14});
        job_hw[2] = 1'b1;
        set_job(3, 0, 15, 15, {8'd48, 4'd5});
        set_job(3, 1, 0, 0, {8'd2, 4'd7});
        set_job(4, 0, 0, 15, {8'd0, 4'd15});
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // random scratchpad image, edges must stay idle meanwhile
        for (int i = 0; i < 64; i++) begin
            for (int b = 0; b < LW; b++) begin
                ram_copy[i][b] = lfsr[31];
                lfsr = lfsr_next(lfsr);
            end
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = 8'(i);
            wr_data = ram_copy[i];
            check_val("act_vld", '0, act_vld);
            check_val("wgt_vld", '0, wgt_vld);
            check_val("act_end", '0, act_end);
            check_val("wgt_end", '0, wgt_end);
        end
        @(negedge clk);
        wr_en = 1'b0;
        for (int j = 0; j < NJOBS; j++) begin
            build_expected(j, 0);
            build_expected(j, 1);
        end
        for (int j = 0; j < NJOBS; j++) begin
            run_job(j);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mm_feed.f ====
+incdir+.
mm_mem_pkg.sv
mm_array_pkg.sv
spad_rd_if.sv
spad_ram.sv
spad_arbiter.sv
mm_skew_buffer.sv
mm_feed_top.sv
mm_feed_tb.sv
